//--- include/io_bridge_consts.svh
`ifndef IO_BRIDGE_CONSTS_SVH
`define IO_BRIDGE_CONSTS_SVH

`define IO_ADDR_W  16       // port address space
`define IO_DATA_W  32       // bus word
`define IO_LANES   4        // bytes per bus word
`define IO_LEN_W   3        // holds lengths 1..4

`endif

//--- hw/io_bridge_pkg.sv
`include "io_bridge_consts.svh"

package io_bridge_pkg;

    typedef logic [`IO_ADDR_W-1:0] io_addr_t;
    typedef logic [`IO_DATA_W-1:0] io_data_t;
    typedef logic [7:0]            io_byte_t;
    typedef logic [`IO_LEN_W-1:0]  io_len_t;     // 1..4 bytes
    typedef logic [`IO_LANES-1:0]  lane_sel_t;
    typedef logic [1:0]            lane_idx_t;   // lane number or byte offset

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } io_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,    // first word on the bus
        ST_SECOND,   // second word, unaligned only
        ST_DONE
    } split_state_e;

endpackage

//--- hw/io_bridge_ifs.sv
`timescale 1ns/100ps
`include "io_bridge_consts.svh"

// ----------------------------------------
// request as latched by the splitter
// ----------------------------------------
interface io_req_if;
    import io_bridge_pkg::*;

    io_op_e                 op;
    lane_idx_t              offset;     // address bits 1:0
    io_len_t                length;
    logic [`IO_ADDR_W-1:2]  word_adr;
    io_data_t               wdata;      // unrotated write data
    logic                   phase;      // 0 first word, 1 second word
    logic                   active;
    logic                   ack;

    modport split  (output op, offset, length, word_adr, wdata, phase, active,
                    input  ack);
    modport lane   (input  op, offset, length, wdata, phase, active, ack);
    modport master (input  op, offset, length, word_adr, phase, active,
                    output ack);
endinterface

// ----------------------------------------
// one byte lane of the bus word
// ----------------------------------------
interface io_lane_if;
    import io_bridge_pkg::*;

    logic       sel;
    io_byte_t   wr_byte;
    io_byte_t   rd_byte;
    lane_idx_t  rd_pos;     // byte position in the cpu data
    io_byte_t   bus_byte;   // slice of wb_dat_r

    modport lane   (output sel, wr_byte, rd_byte, rd_pos,
                    input  bus_byte);
    modport master (input  sel, wr_byte, rd_byte, rd_pos,
                    output bus_byte);
endinterface

//--- hw/io_request_split.sv
`timescale 1ns/100ps
`include "io_bridge_consts.svh"

module io_request_split (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     io_read_do,
    input  io_bridge_pkg::io_addr_t  io_read_address,
    input  io_bridge_pkg::io_len_t   io_read_length,
    output logic                     io_read_done,

    input  logic                     io_write_do,
    input  io_bridge_pkg::io_addr_t  io_write_address,
    input  io_bridge_pkg::io_len_t   io_write_length,
    input  io_bridge_pkg::io_data_t  io_write_data,
    output logic                     io_write_done,

    io_req_if.split                  req
);
    import io_bridge_pkg::*;

    split_state_e state;
    split_state_e state_nxt;
    logic         take_read;
    logic         take_write;
    logic         need_second;

    // read wins when both are raised together
    assign take_read  = (state == ST_IDLE) && io_read_do;
    assign take_write = (state == ST_IDLE) && io_write_do && !io_read_do;

    // access runs past byte 3 of the word
    assign need_second = ({1'b0, req.offset} + req.length) > 3'd4;

    // ----------------------------------------
    // phase sequencing
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (take_read || take_write) state_nxt = ST_FIRST;
            ST_FIRST:  if (req.ack) state_nxt = need_second ? ST_SECOND : ST_DONE;
            ST_SECOND: if (req.ack) state_nxt = ST_DONE;
            ST_DONE:   state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.op       <= OP_READ;
            req.offset   <= '0;
            req.length   <= '0;
            req.word_adr <= '0;
            req.wdata    <= '0;
        end else if (take_read) begin
            req.op       <= OP_READ;
            req.offset   <= io_read_address[1:0];
            req.length   <= io_read_length;
            req.word_adr <= io_read_address[`IO_ADDR_W-1:2];
        end else if (take_write) begin
            req.op       <= OP_WRITE;
            req.offset   <= io_write_address[1:0];
            req.length   <= io_write_length;
            req.word_adr <= io_write_address[`IO_ADDR_W-1:2];
            req.wdata    <= io_write_data;
        end else if (state == ST_FIRST && req.ack && need_second) begin
            req.word_adr <= req.word_adr + 1'b1;   // step to next word
        end
    end

    assign req.active = (state == ST_FIRST) || (state == ST_SECOND);
    assign req.phase  = (state == ST_SECOND);

    assign io_read_done  = (state == ST_DONE) && (req.op == OP_READ);
    assign io_write_done = (state == ST_DONE) && (req.op == OP_WRITE);

    // request fields hold from acceptance through done
    a_latch_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state != ST_IDLE) |=> $stable(req.op) && $stable(req.offset)
                               && $stable(req.length) && $stable(req.wdata));

endmodule

//--- hw/io_byte_lane.sv
`timescale 1ns/100ps

module io_byte_lane #(
    parameter io_bridge_pkg::lane_idx_t LANE = 2'd0
) (
    input  logic    clk,
    input  logic    rst_n,
    io_req_if.lane  req,
    io_lane_if.lane lane
);
    import io_bridge_pkg::*;

    lane_idx_t pos;
    logic      second_word;
    io_byte_t  rd_byte_q;

    // cpu byte that lands on this lane, wraps mod 4
    assign pos = LANE - req.offset;

    // bytes that do not fit above the offset go to the next word
    assign second_word = {1'b0, pos} >= (3'd4 - {1'b0, req.offset});

    assign lane.rd_pos = pos;
    assign lane.sel    = req.active
                         && ({1'b0, pos} < req.length)
                         && (second_word == req.phase);

    // write rotation
    assign lane.wr_byte = req.wdata[8*pos +: 8];

    // ----------------------------------------
    // read capture
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_byte_q <= '0;
        end else if (req.ack && lane.sel && req.op == OP_READ) begin
            rd_byte_q <= lane.bus_byte;
        end
    end

    assign lane.rd_byte = rd_byte_q;

endmodule

//--- hw/io_bus_master.sv
`timescale 1ns/100ps
`include "io_bridge_consts.svh"

module io_bus_master (
    input  logic                      clk,
    input  logic                      rst_n,

    io_req_if.master                  req,
    io_lane_if.master                 lane [`IO_LANES],

    output logic [`IO_ADDR_W-1:2]     wb_adr,
    output io_bridge_pkg::io_data_t   wb_dat_w,
    output io_bridge_pkg::lane_sel_t  wb_sel,
    output logic                      wb_we,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    input  io_bridge_pkg::io_data_t   wb_dat_r,
    input  logic                      wb_ack,

    output io_bridge_pkg::io_data_t   io_read_data
);
    import io_bridge_pkg::*;

    logic      bus_busy;
    logic      last_word;
    io_byte_t  lane_byte [`IO_LANES];
    lane_idx_t lane_pos  [`IO_LANES];
    io_data_t  assembled;
    io_data_t  masked;

    // ----------------------------------------
    // lane fan-in and fan-out
    // ----------------------------------------
    for (genvar g = 0; g < `IO_LANES; g++) begin : g_lane
        assign lane[g].bus_byte    = wb_dat_r[8*g +: 8];
        assign wb_sel[g]           = lane[g].sel;
        assign wb_dat_w[8*g +: 8]  = lane[g].wr_byte;
        assign lane_pos[g]         = lane[g].rd_pos;
        // current word straight off the bus, earlier word from the lane
        assign lane_byte[g] = lane[g].sel ? lane[g].bus_byte : lane[g].rd_byte;
    end

    // ----------------------------------------
    // wishbone classic cycle
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_busy <= 1'b0;
            wb_we    <= 1'b0;
        end else if (bus_busy) begin
            if (wb_ack) begin
                bus_busy <= 1'b0;   // one transaction per word
                wb_we    <= 1'b0;
            end
        end else if (req.active) begin
            bus_busy <= 1'b1;
            wb_we    <= (req.op == OP_WRITE);
        end
    end

    assign wb_cyc  = bus_busy;
    assign wb_stb  = bus_busy;
    assign wb_adr  = req.word_adr;
    assign req.ack = wb_ack && bus_busy;

    assign last_word = req.phase || (({1'b0, req.offset} + req.length) <= 3'd4);

    // gather back to byte 0 upward
    always_comb begin
        assembled = '0;
        for (int i = 0; i < `IO_LANES; i++) begin
            assembled[8*lane_pos[i] +: 8] = lane_byte[i];
        end
        masked = assembled;
        for (int p = 0; p < `IO_LANES; p++) begin
            if (p >= int'(req.length)) begin
                masked[8*p +: 8] = '0;   // past the length
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_read_data <= '0;
        end else if (req.ack && last_word && req.op == OP_READ) begin
            io_read_data <= masked;   // valid with the done pulse
        end
    end

    // bus outputs stay put until the slave acks
    a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel)
                              && $stable(wb_dat_w) && $stable(wb_we));

    a_stb_sel: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc && (wb_sel != '0));

endmodule

//--- hw/io_bridge.sv
`timescale 1ns/100ps
`include "io_bridge_consts.svh"

module io_bridge (
    input  logic                      clk,
    input  logic                      rst_n,

    // cpu port read
    input  logic                      io_read_do,
    input  io_bridge_pkg::io_addr_t   io_read_address,
    input  io_bridge_pkg::io_len_t    io_read_length,
    output io_bridge_pkg::io_data_t   io_read_data,
    output logic                      io_read_done,

    // cpu port write
    input  logic                      io_write_do,
    input  io_bridge_pkg::io_addr_t   io_write_address,
    input  io_bridge_pkg::io_len_t    io_write_length,
    input  io_bridge_pkg::io_data_t   io_write_data,
    output logic                      io_write_done,

    // wishbone classic master
    output logic [`IO_ADDR_W-1:2]     wb_adr,
    output io_bridge_pkg::io_data_t   wb_dat_w,
    output io_bridge_pkg::lane_sel_t  wb_sel,
    output logic                      wb_we,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    input  io_bridge_pkg::io_data_t   wb_dat_r,
    input  logic                      wb_ack
);
    import io_bridge_pkg::*;

    io_req_if  req_if ();
    io_lane_if lane_if [`IO_LANES] ();

    //----------------------------------------
    io_request_split u_split (
        .clk              (clk),
        .rst_n            (rst_n),
        .io_read_do       (io_read_do),
        .io_read_address  (io_read_address),
        .io_read_length   (io_read_length),
        .io_read_done     (io_read_done),
        .io_write_do      (io_write_do),
        .io_write_address (io_write_address),
        .io_write_length  (io_write_length),
        .io_write_data    (io_write_data),
        .io_write_done    (io_write_done),
        .req              (req_if)
    );

    //----------------------------------------
    for (genvar g = 0; g < `IO_LANES; g++) begin : g_lanes
        io_byte_lane #(
            .LANE (lane_idx_t'(g))
        ) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_if),
            .lane  (lane_if[g])
        );
    end

    //----------------------------------------
    io_bus_master u_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req_if),
        .lane         (lane_if),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_we        (wb_we),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .io_read_data (io_read_data)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

//--- sim/tb_io_bridge.sv
`timescale 1ns/100ps
`include "io_bridge_consts.svh"

module tb_io_bridge;
    import io_bridge_pkg::*;

    typedef struct packed {
        io_op_e   op;
        io_addr_t addr;
        io_len_t  len;
        io_data_t wdata;
        io_data_t expect_rd;   // reads only
    } row_t;

    localparam int N_ROWS = 26;
    localparam int LIMIT  = N_ROWS * 20 + 50;

    row_t rows [N_ROWS] = '{
        '{OP_READ,  16'h0000, 3'd1, 32'h0000_0000, 32'h0000_0001},
        '{OP_READ,  16'h0004, 3'd2, 32'h0000_0000, 32'h0000_100D},
        '{OP_READ,  16'h0008, 3'd4, 32'h0000_0000, 32'h221F_1C19},
        '{OP_READ,  16'h0003, 3'd2, 32'h0000_0000, 32'h0000_0D0A},
        '{OP_READ,  16'h0006, 3'd4, 32'h0000_0000, 32'h1C19_1613},
        '{OP_READ,  16'h000B, 3'd3, 32'h0000_0000, 32'h0028_2522},
        '{OP_READ,  16'h000E, 3'd2, 32'h0000_0000, 32'h0000_2E2B},
        '{OP_WRITE, 16'h0010, 3'd1, 32'hEEEE_EE5A, 32'h0000_0000},
        '{OP_WRITE, 16'h0011, 3'd1, 32'hEEEE_EE6B, 32'h0000_0000},
        '{OP_WRITE, 16'h0013, 3'd1, 32'hEEEE_EE7C, 32'h0000_0000},
        '{OP_WRITE, 16'h0018, 3'd2, 32'hEEEE_8D9E, 32'h0000_0000},
        '{OP_WRITE, 16'h0019, 3'd2, 32'hEEEE_AFB0, 32'h0000_0000},
        '{OP_WRITE, 16'h001A, 3'd2, 32'hEEEE_C1D2, 32'h0000_0000},
        '{OP_WRITE, 16'h001B, 3'd2, 32'hEEEE_E3F4, 32'h0000_0000},
        '{OP_WRITE, 16'h0020, 3'd3, 32'hEE05_0607, 32'h0000_0000},
        '{OP_WRITE, 16'h0021, 3'd3, 32'hEE08_090A, 32'h0000_0000},
        '{OP_WRITE, 16'h0022, 3'd3, 32'hEE0B_0C0D, 32'h0000_0000},
        '{OP_WRITE, 16'h0023, 3'd3, 32'hEE0E_0F20, 32'h0000_0000},
        '{OP_WRITE, 16'h0028, 3'd4, 32'h2122_2324, 32'h0000_0000},
        '{OP_WRITE, 16'h0029, 3'd4, 32'h2526_2728, 32'h0000_0000},
        '{OP_WRITE, 16'h002A, 3'd4, 32'h292A_2B2C, 32'h0000_0000},
        '{OP_WRITE, 16'h0002, 3'd1, 32'hFFFF_FFA5, 32'h0000_0000},
        '{OP_READ,  16'h0001, 3'd3, 32'h0000_0000, 32'h000A_A504},   // read-back
        '{OP_WRITE, 16'h0007, 3'd4, 32'h4433_2211, 32'h0000_0000},
        '{OP_READ,  16'h0006, 3'd4, 32'h0000_0000, 32'h3322_1113},
        '{OP_READ,  16'h000A, 3'd2, 32'h0000_0000, 32'h0000_2244}
    };

    logic                   clk;
    logic                   rst_n;
    logic                   io_read_do;
    io_addr_t               io_read_address;
    io_len_t                io_read_length;
    io_data_t               io_read_data;
    logic                   io_read_done;
    logic                   io_write_do;
    io_addr_t               io_write_address;
    io_len_t                io_write_length;
    io_data_t               io_write_data;
    logic                   io_write_done;
    logic [`IO_ADDR_W-1:2]  wb_adr;
    io_data_t               wb_dat_w;
    lane_sel_t              wb_sel;
    logic                   wb_we;
    logic                   wb_cyc;
    logic                   wb_stb;
    io_data_t               wb_dat_r;
    logic                   wb_ack;

    logic [7:0] mem [64];          // slave port space
    io_addr_t   log_adr [$];       // one entry per bus cycle
    lane_sel_t  log_sel [$];
    io_data_t   log_dat [$];
    logic       log_we  [$];
    int         errors     = 0;
    int         mon_errors = 0;
    int         rd_dones   = 0;
    int         wr_dones   = 0;
    int         cycles     = 0;

    tb_clock #(.RESET_CYCLES(8)) u_clock (.clk(clk), .rst_n(rst_n));

    io_bridge DUT (.*);

    // ----------------------------------------
    // compare tasks and helpers
    // ----------------------------------------
    task automatic check_data(input string name, input io_data_t exp, input io_data_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input lane_sel_t exp, input lane_sel_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_adr(input string name, input io_addr_t exp, input io_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // lanes and bytes of one bus word, taken in address order
    function automatic void word_lanes(input row_t r, input io_addr_t wadr,
                                       output lane_sel_t sel, output io_data_t dat);
        io_addr_t b;
        sel = '0;
        dat = '0;
        for (int p = 0; p < int'(r.len); p++) begin
            b = r.addr + io_addr_t'(p);
            if (b[15:2] == wadr[15:2]) begin
                sel[b[1:0]] = 1'b1;
                dat[8*b[1:0] +: 8] = r.wdata[8*p +: 8];
            end
        end
    endfunction

    // ----------------------------------------
    // wishbone slave model
    // ----------------------------------------
    initial begin : wb_slave
        logic [15:0] lfsr;
        logic [1:0]  wait_cnt;
        logic        in_cyc;
        io_data_t    rd_word;
        logic [5:0]  idx;
        lfsr     = 16'd27245;
        wait_cnt = '0;
        in_cyc   = 1'b0;
        rd_word  = '0;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        for (int a = 0; a < 64; a++) begin
            mem[a] = 8'(a * 3 + 1);
        end
        forever begin
            @(posedge clk);
            if (!rst_n || wb_ack) begin
                wb_ack <= 1'b0;
                in_cyc = 1'b0;
            end else if (wb_stb && !in_cyc) begin
                in_cyc = 1'b1;
                wait_cnt[0] = lfsr[0];          // one lfsr step per bit
                lfsr = lfsr_next(lfsr);
                wait_cnt[1] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end else if (in_cyc && wait_cnt != 2'd0) begin
                wait_cnt = wait_cnt - 2'd1;
            end else if (in_cyc) begin
                for (int l = 0; l < `IO_LANES; l++) begin
                    idx = {wb_adr[5:2], 2'(l)};
                    rd_word[8*l +: 8] = mem[idx];
                    if (wb_we && wb_sel[l]) begin
                        mem[idx] <= wb_dat_w[8*l +: 8];
                    end
                end
                wb_dat_r <= rd_word;
                wb_ack   <= 1'b1;
                log_adr.push_back({wb_adr, 2'b00});
                log_sel.push_back(wb_sel);
                log_dat.push_back(wb_dat_w);
                log_we.push_back(wb_we);
            end
        end
    end

    // done pulses and bus hold rules
    initial begin : bus_monitor
        logic      held;
        lane_sel_t p_sel;
        io_data_t  p_dat;
        logic      p_we;
        io_addr_t  p_adr;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                rd_dones += int'(io_read_done);
                wr_dones += int'(io_write_done);
                if (wb_cyc !== wb_stb) begin
                    mon_errors++;
                    $display("wb_cyc and wb_stb differ at %0t", $time);
                end
                if (held && !(wb_stb && {wb_adr, 2'b00} == p_adr && wb_sel == p_sel
                              && wb_dat_w == p_dat && wb_we == p_we)) begin
                    mon_errors++;
                    $display("bus cycle changed before its ack at %0t", $time);
                end
                held  = wb_stb && !wb_ack;
                p_adr = {wb_adr, 2'b00};
                p_sel = wb_sel;
                p_dat = wb_dat_w;
                p_we  = wb_we;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------
    // one table row
    // ----------------------------------------
    task automatic run_row(input int n, input row_t r);
        int         err0;
        int         log0;
        int         rd0;
        int         wr0;
        int         words;
        int         off;
        logic       done_seen;
        io_addr_t   wadr;
        lane_sel_t  sel_exp;
        io_data_t   dat_exp;
        logic [7:0] exp_b;
        logic [7:0] snap [64];
        err0 = errors + mon_errors;
        log0 = log_adr.size();
        rd0  = rd_dones;
        wr0  = wr_dones;
        snap = mem;
        @(posedge clk);
        if (r.op == OP_READ) begin
            io_read_do      <= 1'b1;
            io_read_address <= r.addr;
            io_read_length  <= r.len;
        end else begin
            io_write_do      <= 1'b1;
            io_write_address <= r.addr;
            io_write_length  <= r.len;
            io_write_data    <= r.wdata;
        end
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            done_seen = (r.op == OP_READ) ? io_read_done : io_write_done;
        end
        if (r.op == OP_READ) begin
            check_data("io_read_data", r.expect_rd, io_read_data);
        end
        @(posedge clk);
        io_read_do  <= 1'b0;
        io_write_do <= 1'b0;
        @(posedge clk);                      // let the monitor count
        if ((rd_dones - rd0) + (wr_dones - wr0) != 1) begin
            errors++;
            $display("test %0d gave %0d done pulses instead of one", n,
                     (rd_dones - rd0) + (wr_dones - wr0));
        end
        // words touched by the first and last byte
        words = (int'(r.addr) + int'(r.len) - 1) / 4 - int'(r.addr) / 4 + 1;
        if (log_adr.size() - log0 != words) begin
            errors++;
            $display("test %0d ran %0d bus cycles, %0d were due", n, log_adr.size() - log0, words);
        end else begin
            for (int w = 0; w < words; w++) begin
                wadr = {r.addr[15:2] + 14'(w), 2'b00};
                word_lanes(r, wadr, sel_exp, dat_exp);
                check_adr("wb_adr", wadr, log_adr[log0 + w]);
                check_sel("wb_sel", sel_exp, log_sel[log0 + w]);
                check_data("wb_we", 32'(r.op == OP_WRITE), 32'(log_we[log0 + w]));
                if (r.op == OP_WRITE) begin
                    for (int l = 0; l < `IO_LANES; l++) begin
                        if (!sel_exp[l]) log_dat[log0 + w][8*l +: 8] = '0;   // unused lanes
                    end
                    check_data("wb_dat_w", dat_exp, log_dat[log0 + w]);
                end
            end
        end
        for (int b = 0; b < 64; b++) begin
            off   = b - int'(r.addr);
            exp_b = snap[b];
            if (r.op == OP_WRITE && off >= 0 && off < int'(r.len)) exp_b = r.wdata[8*off +: 8];
            check_data($sformatf("mem[%0d]", b), 32'(exp_b), 32'(mem[b]));
        end
        $display("test %0d %s addr %h len %0d: %s", n, (r.op == OP_READ) ? "read " : "write",
                 r.addr, r.len, (errors + mon_errors == err0) ? "ok" : "mismatch");
    endtask

    // both requests raised together, read goes first
    task automatic run_both(input int n);
        int   err0;
        logic got;
        err0 = errors + mon_errors;
        @(posedge clk);
        io_read_do       <= 1'b1;
        io_read_address  <= 16'h0004;
        io_read_length   <= 3'd1;
        io_write_do      <= 1'b1;
        io_write_address <= 16'h0030;
        io_write_length  <= 3'd2;
        io_write_data    <= 32'h0000_6C5B;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (io_write_done) begin
                errors++;
                $display("write finished before the read at %0t", $time);
            end
            got = io_read_done;
        end
        check_data("io_read_data", 32'h0000_000D, io_read_data);
        @(posedge clk);
        io_read_do <= 1'b0;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = io_write_done;
        end
        @(posedge clk);
        io_write_do <= 1'b0;
        @(posedge clk);
        check_data("mem[48]", 32'h0000_005B, 32'(mem[48]));
        check_data("mem[49]", 32'h0000_006C, 32'(mem[49]));
        check_data("mem[50]", 32'h0000_0097, 32'(mem[50]));   // neighbor untouched
        $display("test %0d read and write together: %s", n,
                 (errors + mon_errors == err0) ? "ok" : "mismatch");
    endtask

    initial begin
        int passed;
        passed           = 0;
        io_read_do       = 1'b0;
        io_read_address  = '0;
        io_read_length   = '0;
        io_write_do      = 1'b0;
        io_write_address = '0;
        io_write_length  = '0;
        io_write_data    = '0;
        @(posedge rst_n);
        @(negedge clk);
        if (wb_cyc || wb_stb || wb_we || io_read_done || io_write_done) begin
            errors++;
            $display("control outputs are not low after reset");
        end
        check_sel("wb_sel", '0, wb_sel);
        check_data("io_read_data", '0, io_read_data);
        for (int i = 0; i < N_ROWS; i++) begin
            int e0;
            e0 = errors + mon_errors;
            run_row(i, rows[i]);
            if (errors + mon_errors == e0) passed++;
        end
        run_both(N_ROWS);
        $display("%0d tests, %0d table rows passed, %0d errors", N_ROWS + 1, passed,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
hw/io_bridge_pkg.sv
hw/io_bridge_ifs.sv
hw/io_request_split.sv
hw/io_byte_lane.sv
hw/io_bus_master.sv
hw/io_bridge.sv
sim/tb_clock.sv
sim/tb_io_bridge.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_io_bridge
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
